/* flist.f */
source/fxp_pkg.sv
source/fxp_op_if.sv
source/fxp_request_capture.sv
source/fxp_arith_core.sv
source/fxp_result_hold.sv
source/fxp_alu_top.sv
verification/fxp_alu_sva.sv
verification/fxp_alu_tb.sv

/* Bender.yml */
package:
  name: fxp_alu

sources:
  - source/fxp_pkg.sv
  - source/fxp_op_if.sv
  - source/fxp_request_capture.sv
  - source/fxp_arith_core.sv
  - source/fxp_result_hold.sv
  - source/fxp_alu_top.sv
  - target: test
    files:
      - verification/fxp_alu_sva.sv
      - verification/fxp_alu_tb.sv

/* verification/fxp_alu_tb.sv */
`timescale 1ns/10ps

module fxp_alu_tb import fxp_pkg::*; ();

	localparam fxp_t Q_ONE = 32'h0001_0000;
	localparam int NUM_ROWS = 18;
	localparam int MAX_HOLD = 7;
	localparam int RESET_CYCLES = 8;
	localparam int TIMEOUT_CYCLES = NUM_ROWS * 20 + RESET_CYCLES;

	typedef struct packed {
		fxp_op_t op;
		fxp_t a;
		fxp_t b;
		fxp_t res;
		logic eq;
		logic gt;
		logic lt;
	} vector_t;

	logic clk = 1'b0;
	logic rst;
	logic req;
	fxp_op_t op;
	fxp_t a;
	fxp_t b;
	logic ack;
	fxp_t result;
	logic eq;
	logic gt;
	logic lt;

	vector_t vectors [NUM_ROWS];
	int errors = 0;
	int checks = 0;
	int cycle_count = 0;
	int ack_rises = 0;
	logic ack_prev = 1'b0;

	fxp_alu_top dut_i (
		.clk(clk),
		.rst(rst),
		.req(req),
		.op(op),
		.a(a),
		.b(b),
		.ack(ack),
		.result(result),
		.eq(eq),
		.gt(gt),
		.lt(lt)
	);

	initial begin
		forever #4 clk = ~clk;
	end

	// each row needs well under 20 cycles
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles with the handshake still open", cycle_count);
			$display("Something failed");
			$finish;
		end
	end

	// counts ack rising edges to see one ack per request
	always @(posedge clk) begin
		if (ack && !ack_prev) begin
			ack_rises++;
		end
		ack_prev <= ack;
	end

	task automatic check_value(input logic [31:0] expected, input logic [31:0] actual,
			input string what);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("FAIL %0t: %s expected %h got %h", $time, what, expected, actual);
		end
	endtask

	task automatic check_outputs(input vector_t v, input string tag);
		check_value(v.res, result, {tag, " result"});
		check_value(v.eq, eq, {tag, " eq"});
		check_value(v.gt, gt, {tag, " gt"});
		check_value(v.lt, lt, {tag, " lt"});
	endtask

	// one four-phase transfer that starts and ends on a falling edge
	task automatic apply_vector(input vector_t v, input int idx);
		int cycles;
		int hold;
		string tag;
		tag = $sformatf("row %0d", idx);
		op = v.op;
		a = v.a;
		b = v.b;
		req = 1'b1;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (!ack);
		// capture, core and output side each add one register
		check_value(3, cycles, {tag, " ack latency"});
		check_outputs(v, tag);
		hold = $urandom % (MAX_HOLD + 1);
		repeat (hold) begin
			@(negedge clk);
			check_value(1, ack, {tag, " ack during hold"});
			check_outputs(v, tag);
		end
		req = 1'b0;
		// operands are free once req is low
		a = $urandom;
		b = $urandom;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (ack);
		check_value(2, cycles, {tag, " ack release"});
		check_outputs(v, tag);
		@(negedge clk);
		check_value(0, ack, {tag, " ack idle"});
	endtask

	initial begin
		int i;
		void'($urandom(19));
		rst = 1'b1;
		req = 1'b0;
		op = op_add;
		a = '0;
		b = '0;
		// op, a, b, result, eq, gt, lt
		vectors[0] = '{op_add, Q_ONE, 32'h0002_0000, 32'h0003_0000, 1'b0, 1'b0, 1'b0};
		vectors[1] = '{op_add, 32'h8001_8000, 32'h8002_4000, 32'h8003_c000, 1'b0, 1'b0, 1'b0};
		vectors[2] = '{op_add, 32'h0005_0000, 32'h8003_0000, 32'h0002_0000, 1'b0, 1'b0, 1'b0};
		vectors[3] = '{op_add, 32'h0002_0000, 32'h8007_8000, 32'h8005_8000, 1'b0, 1'b0, 1'b0};
		vectors[4] = '{op_add, 32'h0004_4000, 32'h8004_4000, 32'h0000_0000, 1'b0, 1'b0, 1'b0};
		vectors[5] = '{op_sub, Q_ONE, 32'h0003_0000, 32'h8002_0000, 1'b0, 1'b0, 1'b0};
		vectors[6] = '{op_sub, 32'h8005_0000, 32'h8002_0000, 32'h8003_0000, 1'b0, 1'b0, 1'b0};
		vectors[7] = '{op_sub, 32'h0006_8000, 32'h0000_0000, 32'h0006_8000, 1'b0, 1'b0, 1'b0};
		vectors[8] = '{op_mul, 32'h0001_8000, 32'h0002_0000, 32'h0003_0000, 1'b0, 1'b0, 1'b0};
		vectors[9] = '{op_mul, 32'h8002_8000, 32'h0004_0000, 32'h800a_0000, 1'b0, 1'b0, 1'b0};
		// 0x8001 * 0x8000 = 0x4000_8000 and the low 16 bits are dropped
		vectors[10] = '{op_mul, 32'h0000_8001, 32'h0000_8000, 32'h0000_4000, 1'b0, 1'b0, 1'b0};
		vectors[11] = '{op_mul, 32'h8003_0000, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0, 1'b0};
		vectors[12] = '{op_cmp, 32'h0003_0000, 32'h8001_0000, 32'h0000_0000, 1'b0, 1'b1, 1'b0};
		vectors[13] = '{op_cmp, 32'h8002_0000, 32'h8001_0000, 32'h0000_0000, 1'b0, 1'b0, 1'b1};
		vectors[14] = '{op_cmp, 32'h0007_4000, 32'h0007_4000, 32'h0000_0000, 1'b1, 1'b0, 1'b0};
		vectors[15] = '{op_cmp, 32'h8000_0000, 32'h0000_0000, 32'h0000_0000, 1'b1, 1'b0, 1'b0};
		vectors[16] = '{op_cmp, 32'h0002_8000, 32'h0001_0000, 32'h0000_0000, 1'b0, 1'b1, 1'b0};
		vectors[17] = '{op_cmp, 32'h8004_0000, 32'h0000_8000, 32'h0000_0000, 1'b0, 1'b0, 1'b1};
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		check_value(0, ack, "ack after reset");
		for (i = 0; i < NUM_ROWS; i++) begin
			apply_vector(vectors[i], i);
		end
		check_value(NUM_ROWS, ack_rises, "number of acks");
		$display("checks run %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

/* verification/fxp_alu_sva.sv */
`timescale 1ns/10ps

module fxp_alu_sva import fxp_pkg::*; (
	input logic clk,
	input logic rst,
	input logic req,
	input logic ack,
	input fxp_t result
);

	ack_low_after_reset: assert property (@(posedge clk) rst |=> !ack)
		else $error("ack not low after reset");

	// the unit never withdraws ack while the requester still holds req
	ack_held_with_req: assert property (@(posedge clk) disable iff (rst) (ack && req) |=> ack)
		else $error("ack dropped while req high");

	result_stable_in_ack: assert property (@(posedge clk) disable iff (rst)
		ack |=> (!ack || $stable(result)))
		else $error("result changed while ack high");

	// release takes one cycle, ack clears one cycle after that
	ack_falls_after_req: assert property (@(posedge clk) disable iff (rst)
		($fell(req) && ack) |-> ##[1:2] !ack)
		else $error("ack did not fall after req dropped");

endmodule

bind fxp_alu_top fxp_alu_sva sva_i (.*);

/* source/fxp_alu_top.sv */
`timescale 1ns/10ps

module fxp_alu_top import fxp_pkg::*; (
	input logic clk,
	input logic rst,
	input logic req,
	input fxp_op_t op,
	input fxp_t a,
	input fxp_t b,
	output logic ack,
	output fxp_t result,
	output logic eq,
	output logic gt,
	output logic lt
);

	// core to output side
	fxp_t core_result;
	logic core_eq;
	logic core_gt;
	logic core_lt;
	logic core_done;

	// input side tells the output side that req has dropped
	logic release_pulse;

	fxp_op_if op_bus_i ();

	fxp_request_capture capture_i (
		.clk(clk),
		.rst(rst),
		.req(req),
		.op(op),
		.a(a),
		.b(b),
		.op_bus(op_bus_i.capture),
		.release_pulse(release_pulse)
	);

	fxp_arith_core core_i (
		.clk(clk),
		.rst(rst),
		.op_bus(op_bus_i.core),
		.result(core_result),
		.eq(core_eq),
		.gt(core_gt),
		.lt(core_lt),
		.done(core_done)
	);

	fxp_result_hold hold_i (
		.clk(clk),
		.rst(rst),
		.done(core_done),
		.release_pulse(release_pulse),
		.result_in(core_result),
		.eq_in(core_eq),
		.gt_in(core_gt),
		.lt_in(core_lt),
		.ack(ack),
		.result(result),
		.eq(eq),
		.gt(gt),
		.lt(lt)
	);

endmodule

/* source/fxp_result_hold.sv */
`timescale 1ns/10ps

module fxp_result_hold import fxp_pkg::*; (
	input logic clk,
	input logic rst,
	input logic done,
	input logic release_pulse,
	input fxp_t result_in,
	input logic eq_in,
	input logic gt_in,
	input logic lt_in,
	output logic ack,
	output fxp_t result,
	output logic eq,
	output logic gt,
	output logic lt
);

	// ack rises one cycle after done and falls one cycle after release
	always_ff @(posedge clk) begin
		if (rst) begin
			ack <= 1'b0;
		end else if (done) begin
			ack <= 1'b1;
		end else if (release_pulse) begin
			ack <= 1'b0;
		end
	end

	// result and flags only change on done
	// they stay put through the whole ack phase and after it
	always_ff @(posedge clk) begin
		if (rst) begin
			result <= '0;
			eq <= 1'b0;
			gt <= 1'b0;
			lt <= 1'b0;
		end else if (done) begin
			result <= result_in;
			eq <= eq_in;
			gt <= gt_in;
			lt <= lt_in;
		end
	end

endmodule

/* source/fxp_arith_core.sv */
`timescale 1ns/10ps

module fxp_arith_core import fxp_pkg::*; (
	input logic clk,
	input logic rst,
	fxp_op_if.core op_bus,
	output fxp_t result,
	output logic eq,
	output logic gt,
	output logic lt,
	output logic done
);

	// operand fields
	logic a_sign;
	logic b_sign;
	logic [MAG_W-1:0] a_mag;
	logic [MAG_W-1:0] b_mag;

	// adder
	logic add_b_sign;
	logic [MAG_W-1:0] sum_mag;
	logic sum_sign;

	// multiplier
	logic [PROD_W-1:0] prod_full;
	logic [MAG_W-1:0] prod_mag;
	logic prod_sign;

	// comparator
	logic a_neg;
	logic b_neg;
	logic cmp_eq;
	logic cmp_gt;
	logic cmp_lt;

	// selected outcome, registered on valid
	fxp_t next_result;
	logic next_eq;
	logic next_gt;
	logic next_lt;

	assign a_sign = op_bus.a[WORD_W-1];
	assign b_sign = op_bus.b[WORD_W-1];
	assign a_mag = op_bus.a[MAG_W-1:0];
	assign b_mag = op_bus.b[MAG_W-1:0];

	// subtract is add with the sign of b flipped
	// a zero b keeps its sign since the result sign is fixed up below anyway
	always_comb begin
		add_b_sign = b_sign;
		if ((op_bus.op == op_sub) && (b_mag != '0)) begin
			add_b_sign = ~b_sign;
		end
	end

	always_comb begin
		if (a_sign == add_b_sign) begin
			// same sign, magnitudes wrap modulo 2^31
			sum_mag = a_mag + b_mag;
			sum_sign = a_sign;
		end else if (a_mag > b_mag) begin
			sum_mag = a_mag - b_mag;
			sum_sign = a_sign;
		end else begin
			sum_mag = b_mag - a_mag;
			sum_sign = add_b_sign;
		end
		// zero is always positive
		if (sum_mag == '0) begin
			sum_sign = 1'b0;
		end
	end

	// 31 x 31 bit magnitude product, keep integer and fraction of Q16.16
	assign prod_full = a_mag * b_mag;
	assign prod_mag = prod_full[MAG_W+FRAC_W-1:FRAC_W];
	assign prod_sign = (a_sign ^ b_sign) && (prod_mag != '0);

	// negative zero counts as zero
	assign a_neg = a_sign && (a_mag != '0);
	assign b_neg = b_sign && (b_mag != '0);

	always_comb begin
		cmp_eq = 1'b0;
		cmp_gt = 1'b0;
		cmp_lt = 1'b0;
		if (a_neg != b_neg) begin
			// signs differ, the positive one is larger
			cmp_gt = b_neg;
			cmp_lt = a_neg;
		end else if (a_mag == b_mag) begin
			cmp_eq = 1'b1;
		end else if (a_neg) begin
			// both negative so the larger magnitude is the smaller value
			cmp_gt = a_mag < b_mag;
			cmp_lt = a_mag > b_mag;
		end else begin
			cmp_gt = a_mag > b_mag;
			cmp_lt = a_mag < b_mag;
		end
	end

	always_comb begin
		next_result = '0;
		next_eq = 1'b0;
		next_gt = 1'b0;
		next_lt = 1'b0;
		case (op_bus.op)
			op_add, op_sub: begin
				next_result = {sum_sign, sum_mag};
			end
			op_mul: begin
				next_result = {prod_sign, prod_mag};
			end
			op_cmp: begin
				// result word stays zero, only the flags carry information
				next_eq = cmp_eq;
				next_gt = cmp_gt;
				next_lt = cmp_lt;
			end
			default: begin
				next_result = '0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			result <= '0;
			eq <= 1'b0;
			gt <= 1'b0;
			lt <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= op_bus.valid;
			if (op_bus.valid) begin
				result <= next_result;
				eq <= next_eq;
				gt <= next_gt;
				lt <= next_lt;
			end
		end
	end

endmodule

/* source/fxp_request_capture.sv */
`timescale 1ns/10ps

module fxp_request_capture import fxp_pkg::*; (
	input logic clk,
	input logic rst,
	input logic req,
	input fxp_op_t op,
	input fxp_t a,
	input fxp_t b,
	fxp_op_if.capture op_bus,
	output logic release_pulse
);

	capture_state_t state;
	capture_state_t state_next;

	// new request seen while nothing is in flight
	logic accept;
	// requester has dropped req after the operation was issued
	logic finish;

	assign accept = (state == st_idle) && req;
	assign finish = (state == st_issued) && !req;

	always_comb begin
		state_next = state;
		case (state)
			st_idle: begin
				if (req) begin
					state_next = st_issued;
				end
			end
			st_issued: begin
				// stay here as long as req is held, however long that is
				if (!req) begin
					state_next = st_idle;
				end
			end
			default: begin
				state_next = st_idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			op_bus.valid <= 1'b0;
			release_pulse <= 1'b0;
		end else begin
			state <= state_next;
			op_bus.valid <= accept;
			release_pulse <= finish;
		end
	end

	// operands are only sampled on the accepting edge
	always_ff @(posedge clk) begin
		if (accept) begin
			op_bus.op <= op;
			op_bus.a <= a;
			op_bus.b <= b;
		end
	end

endmodule

/* source/fxp_op_if.sv */
`timescale 1ns/10ps

interface fxp_op_if import fxp_pkg::*; ();

	// one captured operation
	// op, a and b are stable whenever valid is high
	fxp_op_t op;
	fxp_t a;
	fxp_t b;

	// one cycle pulse per accepted request
	logic valid;

	modport capture (
		output op,
		output a,
		output b,
		output valid
	);

	modport core (
		input op,
		input a,
		input b,
		input valid
	);

endinterface

/* source/fxp_pkg.sv */
package fxp_pkg;

	// Q16.16 sign-magnitude word
	// bit 31 is the sign, bits 30..0 the magnitude
	// the low 16 bits of the magnitude hold the fraction
	localparam int WORD_W = 32;
	localparam int MAG_W = 31;
	localparam int FRAC_W = 16;

	// full width of a magnitude times magnitude product
	localparam int PROD_W = 2 * MAG_W;

	typedef logic [WORD_W-1:0] fxp_t;

	// operations handled by the arithmetic core
	// sub reuses the adder with the sign of b flipped
	typedef enum logic [1:0] {
		op_add = 2'b00,
		op_sub = 2'b01,
		op_mul = 2'b10,
		op_cmp = 2'b11
	} fxp_op_t;

	// input side of the req/ack handshake
	// st_issued means an operation was sent and req has not dropped yet
	typedef enum logic {
		st_idle = 1'b0,
		st_issued = 1'b1
	} capture_state_t;

endpackage
